// File: blit_pkg.sv
`default_nettype none

package blit_pkg;

    localparam int WORD_W  = 16;
    localparam int ADDR_W  = 16;
    localparam int LINES_W = 15;

    typedef logic [WORD_W-1:0] word_t;      // vram data word
    typedef logic [ADDR_W-1:0] addr_t;      // vram word address
    typedef logic [3:0]        nib_mask_t;  // one enable bit per nibble
    typedef logic [3:0]        reg_num_t;   // configuration register number
    typedef logic [1:0]        acc_sel_t;   // vram access in progress

    // host register map
    localparam reg_num_t REG_CTRL  = 4'd0;
    localparam reg_num_t REG_MOD_A = 4'd1;
    localparam reg_num_t REG_MOD_B = 4'd2;
    localparam reg_num_t REG_MOD_D = 4'd3;
    localparam reg_num_t REG_SRC_A = 4'd4;
    localparam reg_num_t REG_SRC_B = 4'd5;
    localparam reg_num_t REG_VAL_C = 4'd6;
    localparam reg_num_t REG_DST_D = 4'd7;
    localparam reg_num_t REG_LINES = 4'd8;
    localparam reg_num_t REG_WORDS = 4'd9;  // a write here queues the blit

    localparam acc_sel_t ACC_NONE = 2'd0;
    localparam acc_sel_t ACC_A    = 2'd1;
    localparam acc_sel_t ACC_B    = 2'd2;
    localparam acc_sel_t ACC_D    = 2'd3;

    typedef struct packed {
        logic [7:0] transp_t;               // transparency byte, REG_CTRL[15:8]
        logic       transp_8b;              // bit 5
        logic       c_use_b;                // bit 3
        logic       b_not;                  // bit 2
        logic       b_const;                // bit 1
        logic       a_const;                // bit 0
    } blit_ctrl_t;

    typedef struct packed {
        blit_ctrl_t         ctrl;
        word_t              mod_a;
        word_t              mod_b;
        word_t              mod_d;
        addr_t              src_a;          // also the constant A value
        addr_t              src_b;          // also the constant B value
        word_t              val_c;
        addr_t              dst_d;
        logic [LINES_W-1:0] lines;          // line count minus one
        logic [15:0]        words;          // word count, zero means 65536
    } blit_cfg_t;

    typedef enum logic [2:0] {
        IDLE,
        SETUP,
        LINE_BEG,
        RD_A,
        RD_B,
        WR_D,
        LINE_END
    } blit_state_t;

endpackage

`default_nettype wire

// File: blit_step_if.sv
`timescale 1ns/1ps
`default_nettype none

interface blit_step_if import blit_pkg::*; ();

    logic     load;                         // working registers take the queue
    logic     line_beg;
    logic     rd_a_done;                    // ack cycle of an A read
    logic     rd_b_done;                    // ack cycle of a B read
    logic     wr_d_done;                    // ack cycle of a D write
    logic     line_end;
    acc_sel_t acc;                          // which address goes to vram

    modport fsm (
        output load, line_beg, rd_a_done, rd_b_done, wr_d_done, line_end, acc
    );

    modport dpath (
        input  load, line_beg, rd_a_done, rd_b_done, wr_d_done, line_end, acc
    );

endinterface

`default_nettype wire

// File: blit_regs.sv
`timescale 1ns/1ps
`default_nettype none

module blit_regs import blit_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       reg_wr_i,       // host write strobe
    input  wire reg_num_t   reg_num_i,
    input  wire word_t      reg_data_i,
    input  wire logic       take_i,         // fsm has copied the queue
    output      blit_cfg_t  cfg_o,          // queued blit
    output      logic       queued_o
);

    logic wr_words;

    assign wr_words = reg_wr_i && (reg_num_i == REG_WORDS);

    // queue contents, overwritten by any host write
    always_ff @(posedge clk) begin
        if (reg_wr_i) begin
            case (reg_num_i)
                REG_CTRL: begin
                    cfg_o.ctrl.transp_t  <= reg_data_i[15:8];
                    cfg_o.ctrl.transp_8b <= reg_data_i[5];
                    cfg_o.ctrl.c_use_b   <= reg_data_i[3];
                    cfg_o.ctrl.b_not     <= reg_data_i[2];
                    cfg_o.ctrl.b_const   <= reg_data_i[1];
                    cfg_o.ctrl.a_const   <= reg_data_i[0];
                end
                REG_MOD_A: begin
                    cfg_o.mod_a <= reg_data_i;
                end
                REG_MOD_B: begin
                    cfg_o.mod_b <= reg_data_i;
                end
                REG_MOD_D: begin
                    cfg_o.mod_d <= reg_data_i;
                end
                REG_SRC_A: begin
                    cfg_o.src_a <= reg_data_i;
                end
                REG_SRC_B: begin
                    cfg_o.src_b <= reg_data_i;
                end
                REG_VAL_C: begin
                    cfg_o.val_c <= reg_data_i;
                end
                REG_DST_D: begin
                    cfg_o.dst_d <= reg_data_i;
                end
                REG_LINES: begin
                    cfg_o.lines <= reg_data_i[LINES_W-1:0];   // top bit dropped
                end
                REG_WORDS: begin
                    cfg_o.words <= reg_data_i;
                end
                default: begin
                end
            endcase
        end
    end

    // queued flag, a new blit wins over the take
    always_ff @(posedge clk) begin
        if (reset_i) begin
            queued_o <= 1'b0;
        end else if (wr_words) begin
            queued_o <= 1'b1;
        end else if (take_i) begin
            queued_o <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: blit_counter.sv
`timescale 1ns/1ps
`default_nettype none

module blit_counter import blit_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire blit_cfg_t  cfg_i,
    input  wire logic       load_i,         // start of a blit
    input  wire logic       word_start_i,   // start of a line
    input  wire logic       word_step_i,    // a word was written
    input  wire logic       line_step_i,
    output      logic       last_word_o,
    output      logic       last_line_o
);

    logic [15:0] words_q;                   // word count of the running blit
    logic [15:0] word_cnt;                  // words left in the line, minus one
    logic [16:0] word_dec;                  // bit 16 set when word_cnt is zero
    logic [15:0] line_cnt;                  // bit 15 underflows after the last line

    assign word_dec    = {1'b0, word_cnt} - 17'd1;
    assign last_word_o = word_dec[16];
    assign last_line_o = line_cnt[15];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            words_q  <= '0;
            word_cnt <= '0;
            line_cnt <= '0;
        end else begin
            if (load_i) begin
                words_q  <= cfg_i.words;
                line_cnt <= {1'b0, cfg_i.lines};
            end
            if (line_step_i) begin
                line_cnt <= line_cnt - 16'd1;   // pre-decrement, like the word count
            end
            if (word_start_i) begin
                word_cnt <= words_q - 16'd1;    // zero wraps to 65536 words
            end else if (word_step_i) begin
                word_cnt <= word_dec[15:0];
            end
        end
    end

endmodule

`default_nettype wire

// File: blit_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module blit_fsm import blit_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       queued_i,
    input  wire blit_ctrl_t ctrl_i,         // control bits of the queued blit
    input  wire logic       last_word_i,
    input  wire logic       last_line_i,
    input  wire logic       vram_ack_i,
    blit_step_if.fsm        step,
    output      logic       take_o,
    output      logic       load_o,
    output      logic       word_start_o,
    output      logic       word_step_o,
    output      logic       line_step_o,
    output      logic       vram_sel_o,
    output      logic       vram_wr_o,
    output      logic       busy_o,
    output      logic       done_intr_o
);

    blit_state_t state;
    blit_state_t state_nxt;
    blit_state_t first_acc;                 // first access of each word
    logic        a_const_q;
    logic        b_const_q;

    assign first_acc = !a_const_q ? RD_A :
                       !b_const_q ? RD_B : WR_D;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (queued_i) begin
                    state_nxt = SETUP;
                end
            end
            SETUP: begin
                state_nxt = LINE_BEG;
            end
            LINE_BEG: begin
                state_nxt = first_acc;
            end
            RD_A: begin
                if (vram_ack_i) begin
                    state_nxt = b_const_q ? WR_D : RD_B;
                end
            end
            RD_B: begin
                if (vram_ack_i) begin
                    state_nxt = WR_D;
                end
            end
            WR_D: begin
                if (vram_ack_i) begin
                    state_nxt = last_word_i ? LINE_END : first_acc;
                end
            end
            LINE_END: begin
                if (!last_line_i) begin
                    state_nxt = LINE_BEG;
                end else if (queued_i) begin
                    state_nxt = SETUP;      // next blit starts right away
                end else begin
                    state_nxt = IDLE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state       <= IDLE;
            vram_sel_o  <= 1'b0;
            vram_wr_o   <= 1'b0;
            done_intr_o <= 1'b0;
            a_const_q   <= 1'b0;
            b_const_q   <= 1'b0;
        end else begin
            state       <= state_nxt;
            // held high across wait cycles, since state_nxt stays put without ack
            vram_sel_o  <= (state_nxt == RD_A) || (state_nxt == RD_B) || (state_nxt == WR_D);
            vram_wr_o   <= (state_nxt == WR_D);
            done_intr_o <= (state == LINE_END) && last_line_i;
            if (state == SETUP) begin
                a_const_q <= ctrl_i.a_const;
                b_const_q <= ctrl_i.b_const;
            end
        end
    end

    assign busy_o       = (state != IDLE);
    assign take_o       = (state == SETUP);
    assign load_o       = (state == SETUP);
    assign word_start_o = (state == LINE_BEG);
    assign line_step_o  = (state == LINE_BEG);
    assign word_step_o  = (state == WR_D) && vram_ack_i;

    assign step.load      = (state == SETUP);
    assign step.line_beg  = (state == LINE_BEG);
    assign step.rd_a_done = (state == RD_A) && vram_ack_i;
    assign step.rd_b_done = (state == RD_B) && vram_ack_i;
    assign step.wr_d_done = (state == WR_D) && vram_ack_i;
    assign step.line_end  = (state == LINE_END);
    assign step.acc       = (state == RD_A) ? ACC_A :
                            (state == RD_B) ? ACC_B :
                            (state == WR_D) ? ACC_D : ACC_NONE;

endmodule

`default_nettype wire

// File: blit_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module blit_datapath import blit_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire blit_cfg_t  cfg_i,
    blit_step_if.dpath      step,
    input  wire word_t      vram_data_i,
    output      addr_t      vram_addr_o,
    output      word_t      vram_data_o,
    output      nib_mask_t  vram_mask_o
);

    blit_ctrl_t ctrl_q;
    word_t      mod_a;
    word_t      mod_b;
    word_t      mod_d;
    addr_t      src_a;
    addr_t      src_b;
    addr_t      dst_d;
    word_t      val_a;                      // read A or the constant
    word_t      val_b;                      // raw B, before any inversion
    word_t      val_c;
    nib_mask_t  mask_q;
    word_t      b_eff;

    // a nibble is written only where B differs from the transparency value
    function automatic nib_mask_t transp_mask(input word_t b, input blit_ctrl_t c);
        nib_mask_t m4;
        nib_mask_t m8;
        m4 = {b[15:12] != c.transp_t[7:4], b[11:8] != c.transp_t[3:0],
              b[7:4]   != c.transp_t[7:4], b[3:0]  != c.transp_t[3:0]};
        m8 = {{2{b[15:8] != c.transp_t}}, {2{b[7:0] != c.transp_t}}};
        return c.transp_8b ? m8 : m4;
    endfunction

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ctrl_q <= '0;
            mask_q <= '0;
        end else if (step.load) begin
            ctrl_q <= cfg_i.ctrl;
            mask_q <= transp_mask(cfg_i.src_b, cfg_i.ctrl);     // constant B case
        end else if (step.rd_b_done) begin
            mask_q <= transp_mask(vram_data_i, ctrl_q);
        end else if (step.line_beg) begin
            mask_q <= transp_mask(val_b, ctrl_q);
        end
    end

    always_ff @(posedge clk) begin
        if (step.load) begin
            mod_a <= cfg_i.mod_a;
            mod_b <= cfg_i.mod_b;
            mod_d <= cfg_i.mod_d;
            src_a <= cfg_i.src_a;
            src_b <= cfg_i.src_b;
            dst_d <= cfg_i.dst_d;
            val_a <= cfg_i.src_a;
            val_b <= cfg_i.src_b;
            val_c <= cfg_i.ctrl.c_use_b ? cfg_i.src_b : cfg_i.val_c;
        end else begin
            if (step.rd_a_done) begin
                val_a <= vram_data_i;
                src_a <= src_a + 16'd1;
            end
            if (step.rd_b_done) begin
                val_b <= vram_data_i;
                src_b <= src_b + 16'd1;
                if (ctrl_q.c_use_b) begin
                    val_c <= vram_data_i;
                end
            end
            if (step.wr_d_done) begin
                dst_d <= dst_d + 16'd1;
            end
            if (step.line_end) begin
                src_a <= src_a + mod_a;     // constants stay fixed
                src_b <= src_b + mod_b;
                dst_d <= dst_d + mod_d;
            end
        end
    end

    assign b_eff       = ctrl_q.b_not ? ~val_b : val_b;
    assign vram_data_o = (val_a & b_eff) ^ val_c;
    assign vram_mask_o = mask_q;

    always_comb begin
        case (step.acc)
            ACC_A:   vram_addr_o = src_a;
            ACC_B:   vram_addr_o = src_b;
            ACC_D:   vram_addr_o = dst_d;
            default: vram_addr_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: blitter_top.sv
`timescale 1ns/1ps
`default_nettype none

module blitter_top import blit_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       reg_wr_i,
    input  wire reg_num_t   reg_num_i,
    input  wire word_t      reg_data_i,
    input  wire logic       vram_ack_i,
    input  wire word_t      vram_data_i,
    output      logic       busy_o,
    output      logic       full_o,
    output      logic       done_intr_o,
    output      logic       vram_sel_o,
    output      logic       vram_wr_o,
    output      addr_t      vram_addr_o,
    output      word_t      vram_data_o,
    output      nib_mask_t  vram_mask_o
);

    blit_cfg_t cfg;                         // queued blit
    logic      queued;
    logic      take;
    logic      load;
    logic      word_start;
    logic      word_step;
    logic      line_step;
    logic      last_word;
    logic      last_line;

    blit_step_if step_if ();

    assign full_o = queued;

    blit_regs regs0 (
        .clk        (clk),
        .reset_i    (reset_i),
        .reg_wr_i   (reg_wr_i),
        .reg_num_i  (reg_num_i),
        .reg_data_i (reg_data_i),
        .take_i     (take),
        .cfg_o      (cfg),
        .queued_o   (queued)
    );

    blit_counter cnt0 (
        .clk          (clk),
        .reset_i      (reset_i),
        .cfg_i        (cfg),
        .load_i       (load),
        .word_start_i (word_start),
        .word_step_i  (word_step),
        .line_step_i  (line_step),
        .last_word_o  (last_word),
        .last_line_o  (last_line)
    );

    blit_fsm fsm0 (
        .clk          (clk),
        .reset_i      (reset_i),
        .queued_i     (queued),
        .ctrl_i       (cfg.ctrl),
        .last_word_i  (last_word),
        .last_line_i  (last_line),
        .vram_ack_i   (vram_ack_i),
        .step         (step_if.fsm),
        .take_o       (take),
        .load_o       (load),
        .word_start_o (word_start),
        .word_step_o  (word_step),
        .line_step_o  (line_step),
        .vram_sel_o   (vram_sel_o),
        .vram_wr_o    (vram_wr_o),
        .busy_o       (busy_o),
        .done_intr_o  (done_intr_o)
    );

    blit_datapath dp0 (
        .clk         (clk),
        .reset_i     (reset_i),
        .cfg_i       (cfg),
        .step        (step_if.dpath),
        .vram_data_i (vram_data_i),
        .vram_addr_o (vram_addr_o),
        .vram_data_o (vram_data_o),
        .vram_mask_o (vram_mask_o)
    );

endmodule

`default_nettype wire

// File: tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker import blit_pkg::*; #(
    parameter int NROWS = 1
) (
    input  wire logic        clk,
    input  wire logic        reset_i,
    input  wire logic        reg_wr_i,
    input  wire reg_num_t    reg_num_i,
    input  wire logic        busy_i,
    input  wire logic        full_i,
    input  wire logic        done_intr_i,
    input  wire logic        vram_sel_i,
    input  wire logic        vram_wr_i,
    input  wire logic        vram_ack_i,
    input  wire addr_t       vram_addr_i,
    input  wire word_t       vram_data_i,
    input  wire nib_mask_t   vram_mask_i,
    input  wire logic        idle_chk_i,     // nothing may happen in this window
    input  wire logic        final_i,
    input  wire logic [15:0] tab_i [NROWS][10],
    output int               err_data_o,
    output int               err_addr_o,
    output int               err_mask_o,
    output int               err_ctl_o,
    output int               blits_o         // done pulses seen
);

    int   line;
    int   word;
    int   rd_phase;                          // reads seen for the current word
    int   writes;
    logic words_wr_q;
    logic full_q;                            // full in the cycle before

    function automatic logic [15:0] field(input int r, input reg_num_t n);
        return tab_i[r][int'(n)];
    endfunction

    // channel address for a word: each line advances by words plus modulo
    function automatic addr_t chan_addr(input int r, input int ln, input int wd,
                                        input reg_num_t base, input reg_num_t md);
        addr_t stride;
        stride = field(r, REG_WORDS) + field(r, md);
        return field(r, base) + addr_t'(ln) * stride + addr_t'(wd);
    endfunction

    function automatic nib_mask_t exp_mask(input word_t b, input logic [7:0] t,
                                           input logic m8);
        nib_mask_t m;
        logic      hit;
        for (int k = 0; k < 4; k++) begin
            if (m8) begin
                hit = (b[(k/2)*8 +: 8] == t);
            end else begin
                hit = (b[k*4 +: 4] == ((k % 2) ? t[7:4] : t[3:0]));
            end
            m[k] = !hit;
        end
        return m;
    endfunction

    always @(posedge clk) begin
        logic [15:0] ctrl;
        word_t       a;
        word_t       b;
        word_t       c;
        word_t       d;
        addr_t       exp_addr;
        int          exp_writes;
        if (reset_i) begin
            line       = 0;
            word       = 0;
            rd_phase   = 0;
            writes     = 0;
            words_wr_q = 1'b0;
            full_q     = 1'b0;
            err_data_o = 0;
            err_addr_o = 0;
            err_mask_o = 0;
            err_ctl_o  = 0;
            blits_o    = 0;
        end else begin
            if (idle_chk_i && (busy_i || full_i || vram_sel_i || done_intr_i)) begin
                $display("Error at %0t: activity without any register write", $time);
                err_ctl_o++;
            end
            if (words_wr_q && !full_i) begin
                $display("Error at %0t: full not raised after a word count write", $time);
                err_ctl_o++;
            end
            words_wr_q = reg_wr_i && (reg_num_i == REG_WORDS);
            if (vram_sel_i && vram_ack_i && blits_o >= NROWS) begin
                $display("Error at %0t: vram access after the last blit", $time);
                err_ctl_o++;
            end else if (vram_sel_i && vram_ack_i && !vram_wr_i) begin
                ctrl = field(blits_o, REG_CTRL);
                if (rd_phase == 0 && !ctrl[0]) begin
                    exp_addr = chan_addr(blits_o, line, word, REG_SRC_A, REG_MOD_A);
                end else begin
                    exp_addr = chan_addr(blits_o, line, word, REG_SRC_B, REG_MOD_B);
                end
                if (ctrl[1] && (ctrl[0] || rd_phase > 0)) begin
                    $display("Error at %0t: read of a constant source", $time);
                    err_ctl_o++;
                end else if (vram_addr_i !== exp_addr) begin
                    $display("Error at %0t: read address %h, expected %h", $time,
                             vram_addr_i, exp_addr);
                    err_addr_o++;
                end
                rd_phase++;
            end else if (vram_sel_i && vram_ack_i) begin
                ctrl = field(blits_o, REG_CTRL);
                a = ctrl[0] ? field(blits_o, REG_SRC_A) :
                    tb_blitter.vram[chan_addr(blits_o, line, word, REG_SRC_A, REG_MOD_A)];
                b = ctrl[1] ? field(blits_o, REG_SRC_B) :
                    tb_blitter.vram[chan_addr(blits_o, line, word, REG_SRC_B, REG_MOD_B)];
                c = ctrl[3] ? b : field(blits_o, REG_VAL_C);
                d = (a & (ctrl[2] ? ~b : b)) ^ c;
                exp_addr = chan_addr(blits_o, line, word, REG_DST_D, REG_MOD_D);
                if (rd_phase != int'(!ctrl[0]) + int'(!ctrl[1])) begin
                    $display("Error at %0t: %0d reads before write", $time, rd_phase);
                    err_ctl_o++;
                end
                if (vram_addr_i !== exp_addr) begin
                    $display("Error at %0t: write address %h, expected %h", $time,
                             vram_addr_i, exp_addr);
                    err_addr_o++;
                end
                if (vram_data_i !== d) begin
                    $display("Error at %0t: write data %h, expected %h at %h", $time,
                             vram_data_i, d, exp_addr);
                    err_data_o++;
                end
                if (vram_mask_i !== exp_mask(b, ctrl[15:8], ctrl[5])) begin
                    $display("Error at %0t: write mask %b, expected %b at %h", $time,
                             vram_mask_i, exp_mask(b, ctrl[15:8], ctrl[5]), exp_addr);
                    err_mask_o++;
                end
                rd_phase = 0;
                writes++;
                word++;
                if (word == int'(field(blits_o, REG_WORDS))) begin
                    word = 0;
                    line++;
                end
            end
            if (done_intr_i) begin
                if (blits_o >= NROWS || line != int'(field(blits_o, REG_LINES))) begin
                    $display("Error at %0t: done pulse before the blit ended", $time);
                    err_ctl_o++;
                end
                if (busy_i != full_q) begin                 // next blit starts at once
                    $display("Error at %0t: busy %b at done, full %b before it", $time,
                             busy_i, full_q);
                    err_ctl_o++;
                end
                blits_o++;
                line = 0;
                word = 0;
            end
            full_q = full_i;
            if (final_i) begin
                exp_writes = 0;
                for (int r = 0; r < NROWS; r++) begin
                    exp_writes += int'(field(r, REG_LINES)) * int'(field(r, REG_WORDS));
                end
                if (writes != exp_writes || blits_o != NROWS || busy_i || full_i) begin
                    $display("Error at %0t: %0d writes and %0d blits, expected %0d and %0d",
                             $time, writes, blits_o, exp_writes, NROWS);
                    err_ctl_o++;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_blitter.sv
`timescale 1ns/1ps
`default_nettype none

module tb_blitter import blit_pkg::*; ();

    localparam int NROWS  = 7;
    localparam int SEED   = 52;
    localparam int MARGIN = 600;

    // ctrl, mod a, mod b, mod d, src a, src b, val c, dst d, lines, words
    localparam logic [15:0] TAB [NROWS][10] = '{
        '{16'h0002, 16'h0004, 16'h0000, 16'h0008, 16'h1000, 16'hffff, 16'h0000, 16'h8000, 3, 5},
        '{16'h0003, 16'h0000, 16'h0000, 16'h0002, 16'h1234, 16'h0ff0, 16'h5a5a, 16'h8100, 2, 4},
        '{16'h0004, 16'h0000, 16'h0003, 16'h0001, 16'h1100, 16'h2000, 16'h00ff, 16'h8200, 2, 6},
        '{16'h2008, 16'h0001, 16'h0001, 16'h0002, 16'h1200, 16'h2040, 16'hbeef, 16'h8300, 3, 3},
        '{16'h4b0c, 16'h0000, 16'h0000, 16'h0000, 16'h1300, 16'h2080, 16'h1111, 16'h8400, 2, 4},
        '{16'hc220, 16'h0000, 16'h0000, 16'h0000, 16'h1380, 16'h20c0, 16'h0000, 16'h8500, 2, 4},
        '{16'h5a22, 16'h0002, 16'h0000, 16'h0001, 16'h1400, 16'h5a13, 16'h0f0f, 16'h8600, 1, 3}
    };

    logic      clk;
    logic      reset_i;
    logic      reg_wr;
    reg_num_t  reg_num;
    word_t     reg_data;
    logic      vram_ack;
    word_t     vram_rdata;
    logic      idle_chk;
    logic      final_chk;
    logic      busy, full, done_intr, vram_sel, vram_wr;
    addr_t     vram_addr;
    word_t     vram_wdata;
    nib_mask_t vram_mask;
    word_t     vram [0:65535];
    int        err_data, err_addr, err_mask, err_ctl, blits;
    int        cycles;
    int        limit;
    logic      in_access;
    int        wait_left;

    blitter_top dut0 (
        .clk(clk), .reset_i(reset_i), .reg_wr_i(reg_wr), .reg_num_i(reg_num),
        .reg_data_i(reg_data), .vram_ack_i(vram_ack), .vram_data_i(vram_rdata),
        .busy_o(busy), .full_o(full), .done_intr_o(done_intr), .vram_sel_o(vram_sel),
        .vram_wr_o(vram_wr), .vram_addr_o(vram_addr), .vram_data_o(vram_wdata),
        .vram_mask_o(vram_mask)
    );

    tb_checker #(.NROWS(NROWS)) chk0 (
        .clk(clk), .reset_i(reset_i), .reg_wr_i(reg_wr), .reg_num_i(reg_num),
        .busy_i(busy), .full_i(full), .done_intr_i(done_intr), .vram_sel_i(vram_sel),
        .vram_wr_i(vram_wr), .vram_ack_i(vram_ack), .vram_addr_i(vram_addr),
        .vram_data_i(vram_wdata), .vram_mask_i(vram_mask), .idle_chk_i(idle_chk),
        .final_i(final_chk), .tab_i(TAB), .err_data_o(err_data), .err_addr_o(err_addr),
        .err_mask_o(err_mask), .err_ctl_o(err_ctl), .blits_o(blits)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // vram model, ack after 0 to 3 wait cycles, writes land under the nibble mask
    always @(posedge clk) begin
        if (vram_sel && vram_ack && vram_wr) begin
            for (int k = 0; k < 4; k++) begin
                if (vram_mask[k]) begin
                    vram[vram_addr][k*4 +: 4] = vram_wdata[k*4 +: 4];
                end
            end
        end
        #1;
        if (vram_ack || reset_i) begin
            vram_ack = 1'b0;
            in_access = 1'b0;
        end
        if (vram_sel && !in_access && !reset_i) begin
            in_access = 1'b1;
            wait_left = int'($urandom % 4);
        end
        if (in_access && wait_left == 0) begin
            vram_ack = 1'b1;
            vram_rdata = vram[vram_addr];
        end else if (in_access) begin
            wait_left--;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= limit) begin
            $display("timeout: the blits did not finish within %0d cycles", limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic write_row(input int r);
        for (int k = 0; k < 10; k++) begin
            reg_num  = reg_num_t'(k);
            reg_data = (k == int'(REG_LINES)) ? TAB[r][k] - 16'd1 : TAB[r][k];
            reg_wr   = 1'b1;
            @(posedge clk);
            #1;
        end
        reg_wr = 1'b0;
    endtask

    initial begin
        int total;
        void'($urandom(SEED));
        total = 0;
        for (int r = 0; r < NROWS; r++) begin
            total += int'(TAB[r][8]) * int'(TAB[r][9]);
        end
        limit = total * 3 * 8 + NROWS * 40 + MARGIN;
        cycles = 0;
        for (int i = 0; i < 65536; i++) begin
            vram[i] = {i[7:0], i[15:8]};    // byte swap of the address
        end
        reset_i = 1'b1; reg_wr = 1'b0; reg_num = '0; reg_data = '0;
        vram_ack = 1'b0; vram_rdata = '0; in_access = 1'b0; wait_left = 0;
        idle_chk = 1'b0; final_chk = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        reset_i  = 1'b0;
        idle_chk = 1'b1;
        repeat (20) @(posedge clk);
        #1;
        idle_chk = 1'b0;
        for (int r = 0; r < NROWS; r++) begin
            while (full) begin
                @(posedge clk);
                #1;
            end
            write_row(r);
        end
        while (blits < NROWS || busy) begin
            @(posedge clk);
            #1;
        end
        repeat (4) @(posedge clk);
        #1;
        final_chk = 1'b1;
        @(posedge clk);
        #1;
        final_chk = 1'b0;
        $display("errors: data %0d, address %0d, mask %0d, control %0d, blits done %0d",
                 err_data, err_addr, err_mask, err_ctl, blits);
        if (err_data + err_addr + err_mask + err_ctl == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
blit_pkg.sv
blit_step_if.sv
blit_regs.sv
blit_counter.sv
blit_fsm.sv
blit_datapath.sv
blitter_top.sv
tb_checker.sv
tb_blitter.sv

// File: run.sh
#!/bin/sh
# build and run the blitter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_blitter -f all.f -o tb_blitter_sim
./obj_dir/tb_blitter_sim | tee sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
    exit 0
else
    exit 1
fi
